/* include/mul_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply unit widths and counts
// RV32 operand width, product width and radix-4 row count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// One RV32 word
`define MUL_XLEN 32

// Full product is two words
`define MUL_DXLEN (2 * `MUL_XLEN)

// Radix-4 Booth digits over one word
`define MUL_PP_COUNT (`MUL_XLEN / 2)

`endif

/* verilog/mul_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply unit types
// Word and product vectors, operation codes, request format
// and handshake controller states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mul_defines.svh"

package mul_pkg;

	typedef logic [`MUL_XLEN-1:0] word_t;
	typedef logic [`MUL_DXLEN-1:0] dword_t;

	// Bit 1 for rs1, bit 0 for rs2
	typedef logic [1:0] sign_type_t;

	typedef enum logic [1:0] {
		MUL,
		MULH,
		MULHSU,
		MULHU
	} mul_op_t;

	typedef struct packed {
		mul_op_t op;
		word_t rs1;
		word_t rs2;
	} mul_req_t;

	// Shifted Booth rows, row i already moved left by 2*i
	typedef dword_t [`MUL_PP_COUNT-1:0] pp_array_t;

	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		ACK
	} ctrl_state_t;

endpackage

/* verilog/booth_encoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Booth encoder
// Takes operand magnitudes and recodes the multiplier into
// sixteen radix-4 digits, producing shifted partial products
// plus the sign and top-bit correction flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mul_defines.svh"

module booth_encoder (
	input mul_pkg::word_t multiplicand,
	input mul_pkg::word_t multiplier,
	input mul_pkg::sign_type_t is_signed,
	output mul_pkg::pp_array_t partial_products,
	output logic adjust,
	output mul_pkg::word_t correct_mag,
	output logic add_correction
);

	logic mcand_neg;
	logic mplr_neg;
	mul_pkg::word_t mcand_mag;
	mul_pkg::word_t mplr_mag;
	logic mcand_zero;
	logic [`MUL_XLEN:0] recode_in;
	mul_pkg::dword_t m_pos1;
	mul_pkg::dword_t m_pos2;
	mul_pkg::dword_t m_neg1;
	mul_pkg::dword_t m_neg2;

	// Sign-magnitude conversion
	assign mcand_neg = is_signed[1] & multiplicand[`MUL_XLEN-1];
	assign mplr_neg = is_signed[0] & multiplier[`MUL_XLEN-1];
	assign mcand_mag = mcand_neg ? (~multiplicand + 1'b1) : multiplicand;
	assign mplr_mag = mplr_neg ? (~multiplier + 1'b1) : multiplier;
	assign mcand_zero = (mcand_mag == '0);

	// Product of magnitudes gets negated when exactly one side was negative
	assign adjust = mcand_neg ^ mplr_neg;

	// A magnitude with bit 31 set makes the top digit read negative,
	// so one extra M is added at bit 32 to make it unsigned again
	assign add_correction = mplr_mag[`MUL_XLEN-1];
	assign correct_mag = mcand_mag;

	// Candidate digit values, full product width
	assign m_pos1 = {{`MUL_XLEN{1'b0}}, mcand_mag};
	assign m_pos2 = m_pos1 << 1;
	assign m_neg1 = ~m_pos1 + 1'b1;
	assign m_neg2 = ~m_pos2 + 1'b1;

	assign recode_in = {mplr_mag, 1'b0};

	always_comb begin
		logic [2:0] triple;
		mul_pkg::dword_t term;
		for (int i = 0; i < `MUL_PP_COUNT; i++) begin
			triple = recode_in[2*i +: 3];
			case (triple)
				3'b001, 3'b010: term = m_pos1;
				3'b011: term = m_pos2;
				// Negated terms forced to zero for a zero multiplicand
				3'b100: term = mcand_zero ? '0 : m_neg2;
				3'b101, 3'b110: term = mcand_zero ? '0 : m_neg1;
				default: term = '0;
			endcase
			partial_products[i] = term << (2 * i);
		end
	end

endmodule

/* verilog/wallace_tree.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wallace tree
// Six layers of 3:2 carry-save compressors reduce sixteen
// partial products to a sum and carry pair, with one
// pipeline register between layers 2 and 3
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mul_defines.svh"

module wallace_tree (
	input logic CLK,
	input logic nRST,
	input mul_pkg::pp_array_t partial_products,
	output mul_pkg::dword_t sum,
	output mul_pkg::dword_t carry
);

	typedef struct packed {
		mul_pkg::dword_t s;
		mul_pkg::dword_t c;
	} csa_t;

	// Everything that crosses the mid-tree register
	typedef struct packed {
		csa_t [2:0] l2;
		mul_pkg::dword_t rem_sum;
		mul_pkg::dword_t rem_pp;
	} tree_reg_t;

	csa_t [4:0] l1;
	csa_t [2:0] l2;
	tree_reg_t tree_q;
	csa_t [1:0] l3;
	csa_t [1:0] l4;
	csa_t l5;
	csa_t l6;

	// 3:2 compressor, carry already weighted one bit up
	function automatic csa_t csa(
		input mul_pkg::dword_t x,
		input mul_pkg::dword_t y,
		input mul_pkg::dword_t z
	);
		csa_t r;
		r.s = x ^ y ^ z;
		r.c = ((x & y) | (x & z) | (y & z)) << 1;
		return r;
	endfunction

	// Layer 1 takes rows 0-14 in groups of three, row 15 waits
	always_comb begin
		for (int i = 0; i < 5; i++) begin
			l1[i] = csa(partial_products[3*i], partial_products[3*i+1],
				partial_products[3*i+2]);
		end
	end

	// Layer 2, leaves layer 1 group 4 sum over
	assign l2[0] = csa(l1[0].c, l1[0].s, l1[1].c);
	assign l2[1] = csa(l1[1].s, l1[2].c, l1[2].s);
	assign l2[2] = csa(l1[3].c, l1[3].s, l1[4].c);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			tree_q <= '0;
		end else begin
			tree_q.l2 <= l2;
			tree_q.rem_sum <= l1[4].s;
			tree_q.rem_pp <= partial_products[`MUL_PP_COUNT-1];
		end
	end

	// Layers 3 to 6
	assign l3[0] = csa(tree_q.l2[0].c, tree_q.l2[0].s, tree_q.l2[1].c);
	assign l3[1] = csa(tree_q.l2[1].s, tree_q.l2[2].c, tree_q.l2[2].s);
	assign l4[0] = csa(l3[0].c, l3[0].s, l3[1].c);
	assign l4[1] = csa(l3[1].s, tree_q.rem_pp, tree_q.rem_sum);
	assign l5 = csa(l4[0].c, l4[0].s, l4[1].c);
	assign l6 = csa(l5.c, l5.s, l4[1].s);

	assign sum = l6.s;
	assign carry = l6.c;

endmodule

/* verilog/multiplier.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiplier core
// Three-stage radix-4 Booth / Wallace tree multiplier with a
// sideband pipe for sign and correction, final add and
// completion flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mul_defines.svh"

module multiplier (
	input logic CLK,
	input logic nRST,
	input mul_pkg::word_t multiplicand,
	input mul_pkg::word_t multiplier,
	input mul_pkg::sign_type_t is_signed,
	input logic start,
	output logic finished,
	output logic next_finished,
	output mul_pkg::dword_t product
);

	typedef struct packed {
		logic adjust;
		logic add_correction;
		mul_pkg::word_t correct_mag;
	} side_t;

	mul_pkg::word_t mcand_q;
	mul_pkg::word_t mplr_q;
	mul_pkg::sign_type_t sign_q;
	mul_pkg::pp_array_t pp_comb;
	mul_pkg::pp_array_t pp_q;
	side_t side_comb;
	side_t side1_q;
	side_t side2_q;
	mul_pkg::dword_t tree_sum;
	mul_pkg::dword_t tree_carry;
	mul_pkg::dword_t raw_sum;
	mul_pkg::dword_t corrected;
	logic start_q;

	// Operand capture
	always_ff @(posedge CLK) begin
		if (start) begin
			mcand_q <= multiplicand;
			mplr_q <= multiplier;
			sign_q <= is_signed;
		end
	end

	booth_encoder u_booth_encoder (
		.multiplicand(mcand_q),
		.multiplier(mplr_q),
		.is_signed(sign_q),
		.partial_products(pp_comb),
		.adjust(side_comb.adjust),
		.correct_mag(side_comb.correct_mag),
		.add_correction(side_comb.add_correction)
	);

	// Partial-product register and sideband kept in step with the tree
	always_ff @(posedge CLK) begin
		pp_q <= pp_comb;
		side1_q <= side_comb;
		side2_q <= side1_q;
	end

	wallace_tree u_wallace_tree (
		.CLK(CLK),
		.nRST(nRST),
		.partial_products(pp_q),
		.sum(tree_sum),
		.carry(tree_carry)
	);

	// Final carry-propagate add, top-bit correction, sign fix
	assign raw_sum = tree_sum + tree_carry;
	assign corrected = side2_q.add_correction ?
		raw_sum + {side2_q.correct_mag, {`MUL_XLEN{1'b0}}} : raw_sum;
	assign product = side2_q.adjust ? (~corrected + 1'b1) : corrected;

	// start delayed to line up with each stage
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			start_q <= 1'b0;
			next_finished <= 1'b0;
			finished <= 1'b0;
		end else begin
			start_q <= start;
			next_finished <= start_q;
			finished <= next_finished;
		end
	end

endmodule

/* verilog/mul_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32M multiply unit
// Four-phase req/ack front end around the pipelined
// multiplier, decoding MUL/MULH/MULHSU/MULHU into operand
// signedness and result half
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mul_defines.svh"

module mul_unit (
	input logic CLK,
	input logic nRST,
	input logic req,
	input mul_pkg::mul_req_t req_data,
	output logic ack,
	output mul_pkg::word_t rsp
);

	mul_pkg::ctrl_state_t state;
	mul_pkg::ctrl_state_t next_state;
	mul_pkg::sign_type_t sign_type;
	mul_pkg::dword_t product;
	logic sel_high;
	logic sel_high_q;
	logic start;
	logic finished;
	logic rsp_load;

	// Op decode
	always_comb begin
		sign_type = 2'b11;
		sel_high = 1'b1;
		case (req_data.op)
			mul_pkg::MUL: sel_high = 1'b0;
			mul_pkg::MULH: sign_type = 2'b11;
			mul_pkg::MULHSU: sign_type = 2'b10;
			mul_pkg::MULHU: sign_type = 2'b00;
			default: sel_high = 1'b0;
		endcase
	end

	// One transaction at a time
	assign start = (state == mul_pkg::IDLE) && req;
	assign rsp_load = (state == mul_pkg::BUSY) && finished;

	always_comb begin
		next_state = state;
		case (state)
			mul_pkg::IDLE: if (req) next_state = mul_pkg::BUSY;
			mul_pkg::BUSY: if (finished) next_state = mul_pkg::ACK;
			mul_pkg::ACK: if (!req) next_state = mul_pkg::IDLE;
			default: next_state = mul_pkg::IDLE;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= mul_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	assign ack = (state == mul_pkg::ACK);

	// Half select and response word
	always_ff @(posedge CLK) begin
		if (start) begin
			sel_high_q <= sel_high;
		end
		if (rsp_load) begin
			rsp <= sel_high_q ? product[`MUL_DXLEN-1:`MUL_XLEN] : product[`MUL_XLEN-1:0];
		end
	end

	multiplier u_multiplier (
		.CLK(CLK),
		.nRST(nRST),
		.multiplicand(req_data.rs1),
		.multiplier(req_data.rs2),
		.is_signed(sign_type),
		.start(start),
		.finished(finished),
		.next_finished(),
		.product(product)
	);

endmodule

/* dv/clk_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock source, free running with a 4 ns period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module clk_gen (
	output logic CLK
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

endmodule

/* dv/mul_unit_sva.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply unit handshake assertions
// Reset state, four-phase ordering and response stability
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mul_unit_sva (
	input logic CLK,
	input logic nRST,
	input logic req,
	input logic ack,
	input mul_pkg::word_t rsp
);
	timeunit 1ns;
	timeprecision 100ps;

	// Watched by the testbench
	int fail_count = 0;

	ack_low_after_reset: assert property (@(posedge CLK) $rose(nRST) |-> !ack)
		else begin
			$error("ack high when reset was released");
			fail_count++;
		end

	// The edge that raised ack must have seen req high
	ack_rise_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
		$rose(ack) |-> $past(req))
		else begin
			$error("ack rose without req");
			fail_count++;
		end

	rsp_stable_in_ack: assert property (@(posedge CLK) disable iff (!nRST)
		ack && $past(ack) |-> $stable(rsp))
		else begin
			$error("rsp changed while ack was high");
			fail_count++;
		end

	ack_fall_after_req_low: assert property (@(posedge CLK) disable iff (!nRST)
		$fell(ack) |-> !$past(req))
		else begin
			$error("ack fell while req was still high");
			fail_count++;
		end

endmodule

/* dv/tb_mul_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply unit testbench
// Table of directed corner and random requests checked against
// a 64-bit reference product, with latency and hold checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mul_defines.svh"

module tb_mul_unit;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_RANDOM = 200;
	localparam int MAX_HOLD = 10;
	localparam int IDLE_CYCLES = 20;

	typedef struct packed {
		mul_pkg::mul_op_t op;
		mul_pkg::word_t rs1;
		mul_pkg::word_t rs2;
		mul_pkg::word_t exp;
		logic [3:0] hold;
	} entry_t;

	logic CLK;
	logic nRST;
	logic req;
	mul_pkg::mul_req_t req_data;
	logic ack;
	mul_pkg::word_t rsp;

	entry_t stim_table[$];
	int cycle_count = 0;
	int cycle_limit = 0;

	clk_gen u_clk_gen (.CLK(CLK));

	mul_unit i_mul_unit (
		.CLK(CLK),
		.nRST(nRST),
		.req(req),
		.req_data(req_data),
		.ack(ack),
		.rsp(rsp)
	);

	bind mul_unit mul_unit_sva u_mul_unit_sva (
		.CLK(CLK),
		.nRST(nRST),
		.req(req),
		.ack(ack),
		.rsp(rsp)
	);

	// Exact product, each operand extended by its signedness under the op
	function automatic mul_pkg::word_t expected_word(mul_pkg::mul_op_t op,
		mul_pkg::word_t a, mul_pkg::word_t b);
		logic a_signed;
		logic b_signed;
		mul_pkg::dword_t a_ext;
		mul_pkg::dword_t b_ext;
		mul_pkg::dword_t full;
		a_signed = (op != mul_pkg::MULHU);
		b_signed = (op == mul_pkg::MUL) || (op == mul_pkg::MULH);
		a_ext = {{`MUL_XLEN{a_signed & a[`MUL_XLEN-1]}}, a};
		b_ext = {{`MUL_XLEN{b_signed & b[`MUL_XLEN-1]}}, b};
		full = a_ext * b_ext;
		return (op == mul_pkg::MUL) ? full[`MUL_XLEN-1:0] : full[`MUL_DXLEN-1:`MUL_XLEN];
	endfunction

	task automatic add_entry(mul_pkg::mul_op_t op, mul_pkg::word_t a, mul_pkg::word_t b);
		entry_t e;
		e.op = op;
		e.rs1 = a;
		e.rs2 = b;
		e.exp = expected_word(op, a, b);
		e.hold = 4'($urandom_range(MAX_HOLD, 0));
		stim_table.push_back(e);
	endtask

	task automatic check_value(string name, mul_pkg::word_t actual, mul_pkg::word_t expected);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
			$display("test failed");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// Called on a falling edge, returns on a falling edge with ack low
	task automatic run_entry(entry_t e);
		req_data.op = e.op;
		req_data.rs1 = e.rs1;
		req_data.rs2 = e.rs2;
		req = 1'b1;
		// ack due after the fourth rising edge that sees req
		for (int i = 1; i <= 4; i++) begin
			@(negedge CLK);
			check_value("ack", ack, (i == 4));
		end
		check_value("rsp", rsp, e.exp);
		for (int i = 0; i < e.hold; i++) begin
			@(negedge CLK);
			check_value("ack", ack, 1'b1);
			check_value("rsp", rsp, e.exp);
		end
		req = 1'b0;
		@(negedge CLK);
		check_value("ack", ack, 1'b0);
	endtask

	initial begin
		while (cycle_limit == 0 || cycle_count <= cycle_limit) begin
			@(posedge CLK);
			cycle_count++;
		end
		$display("Run did not complete within %0d clock cycles", cycle_limit);
		$display("test failed");
		$fatal(1, "timeout");
	end

	initial begin
		wait (i_mul_unit.u_mul_unit_sva.fail_count != 0);
		$display("A handshake assertion failed at %0t ns", $time);
		$display("test failed");
		$fatal(1, "assertion failure");
	end

	initial begin
		mul_pkg::word_t corners[5];
		mul_pkg::mul_op_t op;
		nRST = 1'b0;
		req = 1'b0;
		req_data = '0;
		void'($urandom(32'hca84_2b12));
		corners[0] = 32'h0000_0000;
		corners[1] = 32'h0000_0001;
		corners[2] = 32'hffff_ffff;
		corners[3] = 32'h8000_0000;
		corners[4] = 32'h7fff_ffff;

		// Every op against every pair of corner operands
		for (int k = 0; k < 4; k++) begin
			op = mul_pkg::mul_op_t'(k);
			foreach (corners[i]) begin
				foreach (corners[j]) begin
					add_entry(op, corners[i], corners[j]);
				end
			end
		end
		for (int n = 0; n < NUM_RANDOM; n++) begin
			op = mul_pkg::mul_op_t'($urandom_range(3, 0));
			add_entry(op, $urandom(), $urandom());
		end
		cycle_limit = stim_table.size() * (8 + MAX_HOLD) + IDLE_CYCLES + 50;

		repeat (5) @(negedge CLK);
		nRST = 1'b1;
		check_value("ack", ack, 1'b0);
		// No response may appear without a request
		repeat (IDLE_CYCLES) begin
			@(negedge CLK);
			check_value("ack", ack, 1'b0);
		end

		foreach (stim_table[i]) begin
			run_entry(stim_table[i]);
		end

		if (i_mul_unit.u_mul_unit_sva.fail_count != 0) begin
			$display("test failed");
			$fatal(1, "assertion failures seen");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

/* tb.f */
+incdir+include
verilog/mul_pkg.sv
verilog/booth_encoder.sv
verilog/wallace_tree.sv
verilog/multiplier.sv
verilog/mul_unit.sv
dv/clk_gen.sv
dv/mul_unit_sva.sv
dv/tb_mul_unit.sv
